// ==== stopwatch.f ====
rtl/stopwatch_pkg.sv
rtl/input_sync.sv
rtl/stopwatch_wb_regs.sv
rtl/time_counter.sv
rtl/stopwatch_top.sv
tb/stopwatch_properties.sv
tb/stopwatch_tb.sv

// ==== Makefile ====
TOP = stopwatch_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f stopwatch.f -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/stopwatch_tb.sv ====
`timescale 1ns/10ps

module stopwatch_tb;

  localparam int CLK_PERIOD  = 20;            // 50 MHz system clock
  localparam int SYNC_STAGES = 2;             // Depth handed to the DUT
  localparam int TICK_HALF   = 8;             // Clocks per half period of the 1 kHz wave
  localparam int ACK_LIMIT   = 8;             // Cycles a bus access may wait for wb_ack
  localparam int N_RANDOM    = 24;            // Random adjust steps in test 4
  localparam int LAST_MS     = 3599999;       // 59:59.999 as one millisecond count
  localparam int TOTAL_TICKS = 1044;          // Ticks sent over all tests
  localparam int OP_CYCLES   = 40;            // Generous cost of one bus or button step
  localparam int WATCHDOG_NS = 2 * CLK_PERIOD *
    (TOTAL_TICKS * 2 * TICK_HALF + (N_RANDOM + 60) * OP_CYCLES + 1000);

  logic clk_high_speed = 1'b0;
  logic rst_n;
  logic clk_1khz;
  logic inc_sec;
  logic inc_min;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  stopwatch_pkg::wb_addr_t wb_adr;
  stopwatch_pkg::wb_data_t wb_dat_w;
  stopwatch_pkg::wb_data_t wb_dat_r;
  logic                    wb_ack;
  stopwatch_pkg::ms_t      time_ms;
  stopwatch_pkg::sec_t     time_sec;
  stopwatch_pkg::min_t     time_min;

  int exp_ms, exp_sec, exp_min;               // Reference time kept by the testbench
  logic cur_en, cur_up;                       // Last control bits written
  int test_errors, total_errors, checks, test_num, tests_failed;
  stopwatch_pkg::wb_data_t word;              // Last bus read result
  int unsigned rnd;
  int kind;

  stopwatch_top #(.SYNC_STAGES(SYNC_STAGES)) u_dut (.*);

  bind stopwatch_top stopwatch_properties u_properties (
    .clk_high_speed (clk_high_speed),
    .rst_n          (rst_n),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_ack         (wb_ack),
    .ms_tick        (ms_tick),
    .en             (en),
    .btn_sec        (btn_sec),
    .btn_min        (btn_min),
    .sw_sec         (sw_sec),
    .sw_min         (sw_min),
    .load           (load),
    .time_ms        (time_ms),
    .time_sec       (time_sec),
    .time_min       (time_min)
  );

  always #(CLK_PERIOD / 2) clk_high_speed = ~clk_high_speed;

  // One millisecond step on the whole time, clamped at both ends
  task automatic advance_ms(input logic up);
    int total;
    total = exp_min * 60000 + exp_sec * 1000 + exp_ms;
    if (up && total < LAST_MS) total++;
    else if (!up && total > 0) total--;
    exp_min = total / 60000;
    exp_sec = (total / 1000) % 60;
    exp_ms  = total % 1000;
  endtask

  // Seconds adjust moves through minutes, ms untouched, clamped at 00:00 and 59:59
  task automatic shift_sec(input logic up);
    int secs;
    secs = exp_min * 60 + exp_sec;
    if (up && secs < 3599) secs++;
    else if (!up && secs > 0) secs--;
    exp_min = secs / 60;
    exp_sec = secs % 60;
  endtask

  task automatic shift_min(input logic up);
    if (up && exp_min < 59) exp_min++;        // Holds at 59
    else if (!up && exp_min > 0) exp_min--;   // Holds at 0
  endtask

  function automatic stopwatch_pkg::wb_data_t time_word(input int ms, input int sec, input int min);
    stopwatch_pkg::wb_data_t w;
    w        = '0;
    w[9:0]   = ms[9:0];                       // Field layout of REG_TIME
    w[21:16] = sec[5:0];
    w[29:24] = min[5:0];
    return w;
  endfunction

  // Drives one access and waits for the ack on falling edges where it is stable
  task automatic bus_access(input logic we, input stopwatch_pkg::wb_addr_t adr,
                            input stopwatch_pkg::wb_data_t wdata,
                            output stopwatch_pkg::wb_data_t rdata);
    int waited;
    waited = 0;
    rdata  = '0;
    @(posedge clk_high_speed);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    @(negedge clk_high_speed);
    while (!wb_ack && waited < ACK_LIMIT) begin
      @(negedge clk_high_speed);
      waited++;
    end
    if (!wb_ack) begin
      $display("No wb_ack within %0d cycles for the access to address %0d at %0t",
               ACK_LIMIT, adr, $time);
      test_errors++;
    end else begin
      rdata = wb_dat_r;                       // Read data is valid with the ack
    end
    @(posedge clk_high_speed);
    wb_cyc <= 1'b0;                           // Strobe ends at the edge after the ack
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic write_reg(input stopwatch_pkg::wb_addr_t adr, input stopwatch_pkg::wb_data_t d);
    stopwatch_pkg::wb_data_t unused;
    bus_access(1'b1, adr, d, unused);
  endtask

  task automatic read_reg(input stopwatch_pkg::wb_addr_t adr, output stopwatch_pkg::wb_data_t d);
    bus_access(1'b0, adr, '0, d);
  endtask

  task automatic set_ctrl(input logic en_bit, input logic up_bit);
    write_reg(stopwatch_pkg::REG_CTRL, {30'd0, up_bit, en_bit});
    cur_en = en_bit;
    cur_up = up_bit;
  endtask

  task automatic load_time(input int ms, input int sec, input int min);
    write_reg(stopwatch_pkg::REG_TIME, time_word(ms, sec, min));
    exp_ms  = ms;
    exp_sec = sec;
    exp_min = min;
  endtask

  task automatic sw_adjust(input logic [1:0] bits);
    write_reg(stopwatch_pkg::REG_ADJ, {30'd0, bits});
    if (bits[0]) shift_sec(cur_up);           // Seconds is served before minutes
    if (bits[1]) shift_min(cur_up);
  endtask

  task automatic send_ticks(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_high_speed);
      clk_1khz <= 1'b1;
      repeat (TICK_HALF) @(posedge clk_high_speed);
      clk_1khz <= 1'b0;
      repeat (TICK_HALF - 1) @(posedge clk_high_speed);
      if (cur_en) advance_ms(cur_up);
    end
  endtask

  task automatic press_button(input logic minutes);
    @(posedge clk_high_speed);
    if (minutes) inc_min <= 1'b1;
    else inc_sec <= 1'b1;
    repeat (SYNC_STAGES + 2) @(posedge clk_high_speed);  // Edge reaches the counter
    inc_min <= 1'b0;
    inc_sec <= 1'b0;
    repeat (SYNC_STAGES + 3) @(posedge clk_high_speed);  // Low level settles before the next press
    if (minutes) shift_min(cur_up);
    else shift_sec(cur_up);
  endtask

  // Wave and button rise together so the adjust lands behind the tick
  task automatic tick_with_button();
    @(posedge clk_high_speed);
    clk_1khz <= 1'b1;
    inc_sec  <= 1'b1;
    repeat (TICK_HALF) @(posedge clk_high_speed);
    clk_1khz <= 1'b0;
    inc_sec  <= 1'b0;
    repeat (TICK_HALF - 1) @(posedge clk_high_speed);
    if (cur_en) advance_ms(cur_up);
    shift_sec(cur_up);
  endtask

  task automatic check_word(input string what, input stopwatch_pkg::wb_data_t got,
                            input stopwatch_pkg::wb_data_t exp);
    checks++;
    assert (got == exp) else begin
      $display("ERR %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_time(input string what);
    stopwatch_pkg::wb_data_t got;
    read_reg(stopwatch_pkg::REG_TIME, got);
    check_word(what, got, time_word(exp_ms, exp_sec, exp_min));
    @(negedge clk_high_speed);                // The time ports are stable between edges
    check_word({what, " on the time ports"}, time_word(time_ms, time_sec, time_min),
               time_word(exp_ms, exp_sec, exp_min));
  endtask

  task automatic close_test(input string name);
    test_num++;
    if (test_errors == 0) begin
      $display("Test %0d %s: PASS", test_num, name);
    end else begin
      $display("Test %0d %s: FAIL with %0d errors", test_num, name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors   = 0;
  endtask

  initial begin
    void'($urandom(32'h8894));
    rst_n    <= 1'b0;
    clk_1khz <= 1'b0;
    inc_sec  <= 1'b0;
    inc_min  <= 1'b0;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= '0;
    wb_dat_w <= '0;
    exp_ms = 0;
    exp_sec = 0;
    exp_min = 0;
    cur_en = 1'b0;
    cur_up = 1'b0;
    repeat (10) @(posedge clk_high_speed);
    rst_n <= 1'b1;

    repeat (5) begin                          // Idle bus must stay silent
      @(negedge clk_high_speed);
      checks++;
      assert (!wb_ack) else begin
        $display("ERR %0t: wb_ack high without a strobe", $time);
        test_errors++;
      end
    end
    read_reg(stopwatch_pkg::REG_CTRL, word);
    check_word("REG_CTRL after reset", word, '0);
    check_time("REG_TIME after reset");
    close_test("reset values");

    set_ctrl(1'b1, 1'b1);
    load_time(990, 58, 0);
    send_ticks(12);
    check_time("up across the seconds carry");
    send_ticks(1003);
    check_time("up across the minutes carry");
    load_time(995, 59, 59);
    send_ticks(10);
    check_time("up hold at 59:59.999");
    close_test("count up");

    set_ctrl(1'b1, 1'b0);
    load_time(3, 0, 1);
    send_ticks(5);
    check_time("down borrow from minutes");
    load_time(4, 0, 0);
    send_ticks(8);
    check_time("down hold at 00:00.000");
    set_ctrl(1'b0, 1'b0);
    load_time(500, 20, 3);
    send_ticks(5);
    check_time("ticks with en cleared");
    close_test("count down and enable");

    set_ctrl(1'b0, 1'b1);
    load_time(100, 59, 58);
    press_button(1'b0);
    check_time("seconds adjust into the next minute");
    press_button(1'b1);
    sw_adjust(2'b10);
    check_time("minutes adjust hold at 59");
    load_time(100, 59, 59);
    sw_adjust(2'b01);
    check_time("seconds adjust hold at 59:59");
    set_ctrl(1'b0, 1'b0);
    load_time(300, 0, 0);
    sw_adjust(2'b01);
    press_button(1'b1);
    check_time("adjusts hold at 00:00");
    load_time(300, 0, 1);
    press_button(1'b0);
    check_time("seconds adjust into the previous minute");
    set_ctrl(1'b1, 1'b1);
    load_time(999, 10, 0);
    tick_with_button();
    check_time("adjust together with a tick");
    load_time(250, 30, 30);
    for (int i = 0; i < N_RANDOM; i++) begin
      rnd  = $urandom;
      kind = int'(rnd % 5);
      set_ctrl(1'b0, rnd[31]);                // Random direction, ticks off
      case (kind)
        0:       press_button(1'b0);
        1:       press_button(1'b1);
        2:       sw_adjust(2'b01);
        3:       sw_adjust(2'b10);
        default: sw_adjust(2'b11);           // Both at once, seconds first
      endcase
      check_time("random adjust");
    end
    close_test("adjusts");

    set_ctrl(1'b0, 1'b1);
    load_time(20, 10, 5);
    check_time("valid load");
    write_reg(stopwatch_pkg::REG_TIME, time_word(20, 60, 7));
    check_time("write with sec 60 ignored");
    write_reg(stopwatch_pkg::REG_TIME, time_word(1000, 10, 7));
    check_time("write with ms 1000 ignored");
    load_time(567, 34, 12);
    check_time("valid load of 12:34.567");
    write_reg(stopwatch_pkg::REG_ADJ, 32'hFFFF_FFFC); // Upper bits set, no adjust bit
    read_reg(stopwatch_pkg::REG_ADJ, word);
    check_word("REG_ADJ readback", word, '0);
    read_reg(stopwatch_pkg::REG_CTRL, word);
    check_word("REG_CTRL readback", word, 32'h2);
    close_test("load checks");

    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             test_num, tests_failed, checks, total_errors);
    if (total_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== tb/stopwatch_properties.sv ====
`timescale 1ns/10ps

module stopwatch_properties (
  input logic                 clk_high_speed,
  input logic                 rst_n,
  input logic                 wb_cyc,
  input logic                 wb_stb,
  input logic                 wb_ack,
  input logic                 ms_tick,    // Synchronized tick inside the DUT
  input logic                 en,
  input logic                 btn_sec,
  input logic                 btn_min,
  input logic                 sw_sec,
  input logic                 sw_min,
  input logic                 load,
  input stopwatch_pkg::ms_t   time_ms,
  input stopwatch_pkg::sec_t  time_sec,
  input stopwatch_pkg::min_t  time_min
);

  logic change_cause;                     // Anything that may move the time on the next edge

  // A tick or a load acts at once, an adjust may wait up to two cycles behind a tick
  assign change_cause = load || (ms_tick && en) || btn_sec || btn_min || sw_sec || sw_min;

  ack_after_strobe: assert property (
    @(posedge clk_high_speed) disable iff (!rst_n)
    wb_ack |-> $past(wb_cyc && wb_stb)    // Ack only answers a strobe
  ) else $error("wb_ack rose without a strobe in the cycle before");

  ack_single_cycle: assert property (
    @(posedge clk_high_speed) disable iff (!rst_n)
    wb_ack |=> !wb_ack                    // Zero wait states, never a double ack
  ) else $error("wb_ack stayed high for two cycles");

  fields_in_range: assert property (
    @(posedge clk_high_speed) disable iff (!rst_n)
    (time_ms <= stopwatch_pkg::MS_MAX) && (time_sec <= stopwatch_pkg::SEC_MAX) &&
    (time_min <= stopwatch_pkg::MIN_MAX)
  ) else $error("A time field is above its maximum");

  time_stable: assert property (
    @(posedge clk_high_speed) disable iff (!rst_n)
    !($past(change_cause, 1) || $past(change_cause, 2) || $past(change_cause, 3))
      |-> $stable({time_min, time_sec, time_ms})
  ) else $error("The time changed without a tick, adjust or load");

endmodule

// ==== rtl/stopwatch_top.sv ====
`timescale 1ns/10ps

module stopwatch_top #(
  parameter int SYNC_STAGES = 2                    // Synchronizer depth, 2 or 3
) (
  input  logic                     clk_high_speed,
  input  logic                     rst_n,
  input  logic                     clk_1khz,        // Asynchronous 1 kHz wave
  input  logic                     inc_sec,         // Asynchronous seconds button
  input  logic                     inc_min,         // Asynchronous minutes button
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  stopwatch_pkg::wb_addr_t  wb_adr,
  input  stopwatch_pkg::wb_data_t  wb_dat_w,
  output stopwatch_pkg::wb_data_t  wb_dat_r,
  output logic                     wb_ack,
  output stopwatch_pkg::ms_t       time_ms,         // Live time, also readable on the bus
  output stopwatch_pkg::sec_t      time_sec,
  output stopwatch_pkg::min_t      time_min
);

  logic                 ms_tick;    // Synchronized tick pulse
  logic                 btn_sec;    // Synchronized seconds button pulse
  logic                 btn_min;    // Synchronized minutes button pulse
  logic                 en;
  logic                 up_down;
  logic                 sw_sec;     // Seconds adjust from REG_ADJ
  logic                 sw_min;     // Minutes adjust from REG_ADJ
  logic                 load;       // Checked REG_TIME write
  stopwatch_pkg::ms_t   load_ms;
  stopwatch_pkg::sec_t  load_sec;
  stopwatch_pkg::min_t  load_min;

  // Hardware inputs enter through the synchronizer
  input_sync #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_input_sync (
    .clk_high_speed (clk_high_speed),
    .rst_n          (rst_n),
    .clk_1khz       (clk_1khz),
    .inc_sec        (inc_sec),
    .inc_min        (inc_min),
    .ms_tick        (ms_tick),
    .btn_sec        (btn_sec),
    .btn_min        (btn_min)
  );

  // Software control and readback over Wishbone
  stopwatch_wb_regs u_wb_regs (
    .clk_high_speed (clk_high_speed),
    .rst_n          (rst_n),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .wb_dat_r       (wb_dat_r),
    .wb_ack         (wb_ack),
    .time_ms        (time_ms),
    .time_sec       (time_sec),
    .time_min       (time_min),
    .en             (en),
    .up_down        (up_down),
    .sw_sec         (sw_sec),
    .sw_min         (sw_min),
    .load           (load),
    .load_ms        (load_ms),
    .load_sec       (load_sec),
    .load_min       (load_min)
  );

  // The counter merges both request sources
  time_counter u_time_counter (
    .clk_high_speed (clk_high_speed),
    .rst_n          (rst_n),
    .ms_tick        (ms_tick),
    .btn_sec        (btn_sec),
    .btn_min        (btn_min),
    .sw_sec         (sw_sec),
    .sw_min         (sw_min),
    .en             (en),
    .up_down        (up_down),
    .load           (load),
    .load_ms        (load_ms),
    .load_sec       (load_sec),
    .load_min       (load_min),
    .time_ms        (time_ms),
    .time_sec       (time_sec),
    .time_min       (time_min)
  );

endmodule

// ==== rtl/time_counter.sv ====
`timescale 1ns/10ps

module time_counter (
  input  logic                 clk_high_speed,
  input  logic                 rst_n,
  input  logic                 ms_tick,    // Synchronized 1 kHz tick
  input  logic                 btn_sec,    // Button seconds adjust pulse
  input  logic                 btn_min,    // Button minutes adjust pulse
  input  logic                 sw_sec,     // Software seconds adjust pulse
  input  logic                 sw_min,     // Software minutes adjust pulse
  input  logic                 en,         // Ticks count only while set
  input  logic                 up_down,    // 1 counts up, 0 counts down
  input  logic                 load,       // Replace the time with load_*
  input  stopwatch_pkg::ms_t   load_ms,    // Already range checked
  input  stopwatch_pkg::sec_t  load_sec,
  input  stopwatch_pkg::min_t  load_min,
  output stopwatch_pkg::ms_t   time_ms,    // Current milliseconds
  output stopwatch_pkg::sec_t  time_sec,   // Current seconds
  output stopwatch_pkg::min_t  time_min    // Current minutes
);

  logic                 tick;          // Tick that is allowed to count
  logic                 pend_sec;      // Seconds adjust waiting behind a tick
  logic                 pend_min;      // Minutes adjust waiting behind a tick or sec adjust
  logic                 want_sec;      // Seconds adjust requested now or earlier
  logic                 want_min;      // Minutes adjust requested now or earlier
  logic                 pend_sec_nxt;
  logic                 pend_min_nxt;
  stopwatch_pkg::ms_t   ms_nxt;
  stopwatch_pkg::sec_t  sec_nxt;
  stopwatch_pkg::min_t  min_nxt;

  assign tick = ms_tick && en;                        // A disabled tick is simply dropped

  // Buttons and bus writes feed the same request, either one is enough
  assign want_sec = pend_sec || btn_sec || sw_sec;
  assign want_min = pend_min || btn_min || sw_min;

  // One action per cycle: load, then tick, then seconds adjust, then minutes adjust
  always_comb begin
    ms_nxt       = time_ms;
    sec_nxt      = time_sec;
    min_nxt      = time_min;
    pend_sec_nxt = want_sec;                          // Requests not served stay pending
    pend_min_nxt = want_min;
    if (load) begin
      ms_nxt       = load_ms;                         // Load beats everything
      sec_nxt      = load_sec;
      min_nxt      = load_min;
      pend_sec_nxt = 1'b0;                            // And throws away pending adjusts
      pend_min_nxt = 1'b0;
    end else if (tick) begin
      if (up_down) begin
        if (time_ms < stopwatch_pkg::MS_MAX) begin
          ms_nxt = time_ms + 10'd1;                   // Plain millisecond step
        end else if (time_sec < stopwatch_pkg::SEC_MAX) begin
          ms_nxt  = '0;                               // Carry into seconds
          sec_nxt = time_sec + 6'd1;
        end else if (time_min < stopwatch_pkg::MIN_MAX) begin
          ms_nxt  = '0;                               // Carry into minutes
          sec_nxt = '0;
          min_nxt = time_min + 6'd1;
        end                                           // Holds at 59:59.999
      end else begin
        if (time_ms != '0) begin
          ms_nxt = time_ms - 10'd1;
        end else if (time_sec != '0) begin
          ms_nxt  = stopwatch_pkg::MS_MAX;            // Borrow from seconds
          sec_nxt = time_sec - 6'd1;
        end else if (time_min != '0) begin
          ms_nxt  = stopwatch_pkg::MS_MAX;            // Borrow from minutes
          sec_nxt = stopwatch_pkg::SEC_MAX;
          min_nxt = time_min - 6'd1;
        end                                           // Holds at 00:00.000
      end
    end else if (want_sec) begin
      pend_sec_nxt = 1'b0;                            // Served, a minutes request may still wait
      if (up_down) begin
        if (time_sec < stopwatch_pkg::SEC_MAX) begin
          sec_nxt = time_sec + 6'd1;
        end else if (time_min < stopwatch_pkg::MIN_MAX) begin
          sec_nxt = '0;                               // Step from 59 into the next minute
          min_nxt = time_min + 6'd1;
        end
      end else begin
        if (time_sec != '0) begin
          sec_nxt = time_sec - 6'd1;
        end else if (time_min != '0) begin
          sec_nxt = stopwatch_pkg::SEC_MAX;           // Step from 0 into the previous minute
          min_nxt = time_min - 6'd1;
        end
      end
    end else if (want_min) begin
      pend_min_nxt = 1'b0;
      if (up_down) begin
        if (time_min < stopwatch_pkg::MIN_MAX) begin
          min_nxt = time_min + 6'd1;                  // Holds at 59, no wrap
        end
      end else begin
        if (time_min != '0) begin
          min_nxt = time_min - 6'd1;                  // Holds at 0, no wrap
        end
      end
    end
  end

  always_ff @(posedge clk_high_speed) begin
    if (!rst_n) begin
      time_ms  <= '0;                                 // Time starts at 00:00.000
      time_sec <= '0;
      time_min <= '0;
      pend_sec <= 1'b0;                               // Nothing waiting after reset
      pend_min <= 1'b0;
    end else begin
      time_ms  <= ms_nxt;
      time_sec <= sec_nxt;
      time_min <= min_nxt;
      pend_sec <= pend_sec_nxt;
      pend_min <= pend_min_nxt;
    end
  end

endmodule

// ==== rtl/stopwatch_wb_regs.sv ====
`timescale 1ns/10ps

module stopwatch_wb_regs (
  input  logic                     clk_high_speed,
  input  logic                     rst_n,
  input  logic                     wb_cyc,      // Bus cycle in progress
  input  logic                     wb_stb,      // Strobe for this slave
  input  logic                     wb_we,       // High for a write
  input  stopwatch_pkg::wb_addr_t  wb_adr,      // Word address
  input  stopwatch_pkg::wb_data_t  wb_dat_w,    // Write data from the master
  output stopwatch_pkg::wb_data_t  wb_dat_r,    // Read data, valid with wb_ack
  output logic                     wb_ack,      // One-cycle acknowledge
  input  stopwatch_pkg::ms_t       time_ms,     // Live milliseconds from the counter
  input  stopwatch_pkg::sec_t      time_sec,    // Live seconds from the counter
  input  stopwatch_pkg::min_t      time_min,    // Live minutes from the counter
  output logic                     en,          // Counting enable
  output logic                     up_down,     // 1 counts up, 0 counts down
  output logic                     sw_sec,      // Software seconds adjust pulse
  output logic                     sw_min,      // Software minutes adjust pulse
  output logic                     load,        // Load pulse for a checked time
  output stopwatch_pkg::ms_t       load_ms,     // Milliseconds to load
  output stopwatch_pkg::sec_t      load_sec,    // Seconds to load
  output stopwatch_pkg::min_t      load_min     // Minutes to load
);

  logic                     access;      // New transfer this cycle
  logic                     wr_ctrl;     // Write to REG_CTRL
  logic                     wr_time;     // Write to REG_TIME
  logic                     wr_adj;      // Write to REG_ADJ
  logic                     time_ok;     // Every field of the write data is in range
  stopwatch_pkg::ms_t       wr_ms;       // Millisecond field of the write data
  stopwatch_pkg::sec_t      wr_sec;      // Seconds field of the write data
  stopwatch_pkg::min_t      wr_min;      // Minutes field of the write data
  stopwatch_pkg::wb_data_t  rd_word;     // Read data before it is registered

  // A transfer starts when the master strobes and the previous ack has gone
  // Blocking on wb_ack keeps a held strobe from being taken twice
  assign access  = wb_cyc && wb_stb && !wb_ack;
  assign wr_ctrl = access && wb_we && (wb_adr == stopwatch_pkg::REG_CTRL);
  assign wr_time = access && wb_we && (wb_adr == stopwatch_pkg::REG_TIME);
  assign wr_adj  = access && wb_we && (wb_adr == stopwatch_pkg::REG_ADJ);

  // Split the REG_TIME write word into its fields
  assign wr_ms  = wb_dat_w[stopwatch_pkg::TIME_MS_LSB  +: 10];
  assign wr_sec = wb_dat_w[stopwatch_pkg::TIME_SEC_LSB +: 6];
  assign wr_min = wb_dat_w[stopwatch_pkg::TIME_MIN_LSB +: 6];

  // A time is only loaded when all three fields are legal, otherwise the write is dropped
  assign time_ok = (wr_ms  <= stopwatch_pkg::MS_MAX)  &&
                   (wr_sec <= stopwatch_pkg::SEC_MAX) &&
                   (wr_min <= stopwatch_pkg::MIN_MAX);

  // Acknowledge exactly one cycle after the strobe, never two cycles in a row
  always_ff @(posedge clk_high_speed) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;                    // Idle bus after reset
    end else begin
      wb_ack <= access;                  // Zero wait states
    end
  end

  // Control bits keep their value until the next write to REG_CTRL
  always_ff @(posedge clk_high_speed) begin
    if (!rst_n) begin
      en      <= 1'b0;                   // Stopped after reset
      up_down <= 1'b0;                   // Down is the reset direction
    end else if (wr_ctrl) begin
      en      <= wb_dat_w[0];            // Bit 0 starts or stops counting
      up_down <= wb_dat_w[1];            // Bit 1 picks the direction
    end
  end

  // Adjust and load pulses line up with the ack cycle
  // The counter acts on them at the following edge
  always_ff @(posedge clk_high_speed) begin
    if (!rst_n) begin
      sw_sec <= 1'b0;
      sw_min <= 1'b0;
      load   <= 1'b0;
    end else begin
      sw_sec <= wr_adj && wb_dat_w[0];   // Seconds adjust request
      sw_min <= wr_adj && wb_dat_w[1];   // Minutes adjust request
      load   <= wr_time && time_ok;      // Only a legal time is passed on
    end
  end

  // Load values are only looked at while load is high
  always_ff @(posedge clk_high_speed) begin
    if (wr_time) begin
      load_ms  <= wr_ms;                 // Captured together with the load pulse
      load_sec <= wr_sec;
      load_min <= wr_min;
    end
  end

  // Read multiplexer, REG_ADJ and unused addresses return zero
  always_comb begin
    rd_word = '0;
    case (wb_adr)
      stopwatch_pkg::REG_CTRL: begin
        rd_word[0] = en;                 // Enable readback
        rd_word[1] = up_down;            // Direction readback
      end
      stopwatch_pkg::REG_TIME: begin
        rd_word[stopwatch_pkg::TIME_MS_LSB  +: 10] = time_ms;  // Live time, not the load value
        rd_word[stopwatch_pkg::TIME_SEC_LSB +: 6]  = time_sec;
        rd_word[stopwatch_pkg::TIME_MIN_LSB +: 6]  = time_min;
      end
      default: rd_word = '0;
    endcase
  end

  // Time is sampled at the strobe edge and held while wb_ack is high
  always_ff @(posedge clk_high_speed) begin
    if (access && !wb_we) begin
      wb_dat_r <= rd_word;               // Registered read data
    end
  end

endmodule

// ==== rtl/input_sync.sv ====
`timescale 1ns/10ps

module input_sync #(
  parameter int SYNC_STAGES = 2           // Flops in each synchronizer chain, 2 or 3
) (
  input  logic clk_high_speed,
  input  logic rst_n,
  input  logic clk_1khz,                  // Asynchronous 1 kHz square wave
  input  logic inc_sec,                   // Asynchronous seconds button
  input  logic inc_min,                   // Asynchronous minutes button
  output logic ms_tick,                   // One-cycle pulse per rising edge of clk_1khz
  output logic btn_sec,                   // One-cycle pulse per press of inc_sec
  output logic btn_min                    // One-cycle pulse per press of inc_min
);

  // All three inputs share one vector so a single chain description covers them
  // Bit 0 is the 1 kHz wave, bit 1 the seconds button, bit 2 the minutes button
  logic [2:0]                    async_in;   // Raw inputs gathered into one vector
  logic [SYNC_STAGES-1:0][2:0]   sync_q;     // Synchronizer chain, stage 0 sees raw input
  logic [2:0]                    prev_q;     // Last synchronized value for edge detect
  logic [2:0]                    pulse_q;    // Registered rising-edge pulses

  assign async_in = {inc_min, inc_sec, clk_1khz}; // Pack inputs in fixed bit order

  always_ff @(posedge clk_high_speed) begin
    if (!rst_n) begin
      sync_q  <= '0;                      // History starts low after reset
      prev_q  <= '0;                      // Matches the cleared chain
      pulse_q <= '0;                      // No pulse leaves during reset
    end else begin
      sync_q[0] <= async_in;              // First stage may go metastable
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];         // Later stages let it settle
      end
      prev_q  <= sync_q[SYNC_STAGES-1];   // Remember the settled level
      pulse_q <= sync_q[SYNC_STAGES-1] & ~prev_q; // High for one cycle on a low to high change
    end
  end

  // The pulse is registered, so an input edge reaches the outputs
  // SYNC_STAGES + 1 edges later and the counter moves one edge after that
  assign ms_tick = pulse_q[0];            // Millisecond tick
  assign btn_sec = pulse_q[1];            // Seconds button press
  assign btn_min = pulse_q[2];            // Minutes button press

endmodule

// ==== rtl/stopwatch_pkg.sv ====
package stopwatch_pkg;

  // Time fields, each sized for its largest legal value
  typedef logic [9:0]  ms_t;          // Milliseconds, 0 to 999
  typedef logic [5:0]  sec_t;         // Seconds, 0 to 59
  typedef logic [5:0]  min_t;         // Minutes, 0 to 59

  // Wishbone port types
  typedef logic [31:0] wb_data_t;     // One full bus word, no byte selects
  typedef logic [3:0]  wb_addr_t;     // Word address inside the block

  // Largest legal value of every field, used for carries, holds and load checks
  localparam ms_t  MS_MAX  = 10'd999; // Last millisecond before a seconds carry
  localparam sec_t SEC_MAX = 6'd59;   // Last second before a minutes carry
  localparam min_t MIN_MAX = 6'd59;   // Top of the range, counting holds here

  // Register map, word offsets
  localparam wb_addr_t REG_CTRL = 4'd0; // Bit 0 en, bit 1 up_down
  localparam wb_addr_t REG_TIME = 4'd1; // Live time on read, load on write
  localparam wb_addr_t REG_ADJ  = 4'd2; // Adjust pulses, write only

  // Bit positions of the time fields in REG_TIME
  localparam int TIME_MS_LSB  = 0;    // ms in bits 9:0
  localparam int TIME_SEC_LSB = 16;   // sec in bits 21:16
  localparam int TIME_MIN_LSB = 24;   // min in bits 29:24

endpackage
